// ==== common/div_pkg.sv ====
package div_pkg;

    // ------------------------------------------------------------
    // controller
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // waiting for a request, rdy_out high
        RUN  = 2'd1,    // capture, load and loop steps
        HOLD = 2'd2     // result valid, waiting on downstream
    } div_state_e;

    // ------------------------------------------------------------
    // upstream request
    // ------------------------------------------------------------
    typedef struct packed {
        fixp_pkg::div_in_t num;     // numerator, Q8.8
        fixp_pkg::div_in_t den;     // denominator, Q8.8
    } div_req_t;

    // ------------------------------------------------------------
    // captured operands, sign split off
    // ------------------------------------------------------------
    typedef struct packed {
        logic           q_sign;     // sign of the quotient
        fixp_pkg::mag_t num_mag;    // |numerator|
        fixp_pkg::mag_t den_mag;    // |denominator|
    } operand_t;

endpackage

// ==== common/fixp_defs.svh ====
`ifndef FIXP_DEFS_SVH
`define FIXP_DEFS_SVH

// ------------------------------------------------------------
// input operand format, signed Q8.8
// ------------------------------------------------------------
`define DIV_INPUT_I  8      // integer bits, sign included
`define DIV_INPUT_F  8      // fraction bits

// ------------------------------------------------------------
// output quotient format, signed Q10.6
// ------------------------------------------------------------
`define OUTPUT_VEC_I 10     // integer bits, sign included
`define OUTPUT_VEC_F 6      // fraction bits

// divider loop: 15 magnitude bits plus 8 fraction bits
`define DIV_ITER     23     // shift-subtract iterations
`define DIV_CNT_W    5      // counter bits, holds 0..DIV_ITER-1

`endif

// ==== common/fixp_pkg.sv ====
`include "fixp_defs.svh"

package fixp_pkg;

    // ------------------------------------------------------------
    // operand side
    // ------------------------------------------------------------

    // signed Q8.8 operand
    typedef logic signed [`DIV_INPUT_I+`DIV_INPUT_F-1:0] div_in_t;

    // unsigned magnitude, operand width less the sign
    typedef logic [`DIV_INPUT_I+`DIV_INPUT_F-2:0] mag_t;

    // ------------------------------------------------------------
    // result side
    // ------------------------------------------------------------

    // signed Q10.6 quotient sent downstream
    typedef logic signed [`OUTPUT_VEC_I+`OUTPUT_VEC_F-1:0] quo_out_t;

endpackage

// ==== divider/div_ctrl.sv ====
`timescale 1ns/100ps

module div_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic vld_in,        // upstream request valid
    input  logic rdy_in,        // downstream can take the result
    input  logic last,          // final loop iteration
    output logic rdy_out,       // free for a new request
    output logic vld_out,       // result on the output
    output logic accept,        // upstream transfer this cycle
    output logic load,          // seed the loop
    output logic step           // one loop iteration
);

    div_pkg::div_state_e state;
    div_pkg::div_state_e state_nxt;
    logic                cap_q;     // operands captured last edge

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    assign rdy_out = (state == div_pkg::IDLE);      // from state only
    assign vld_out = (state == div_pkg::HOLD);
    assign accept  = vld_in && rdy_out;
    assign step    = (state == div_pkg::RUN) && !cap_q && !load;   // after seed

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            div_pkg::IDLE: begin
                if (accept) begin
                    state_nxt = div_pkg::RUN;
                end
            end
            div_pkg::RUN: begin
                if (step && last) begin     // result lands this edge
                    state_nxt = div_pkg::HOLD;
                end
            end
            div_pkg::HOLD: begin
                if (rdy_in) begin           // taken downstream
                    state_nxt = div_pkg::IDLE;
                end
            end
            default: state_nxt = div_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= div_pkg::IDLE;
            cap_q <= 1'b0;
            load  <= 1'b0;
        end else begin
            state <= state_nxt;
            cap_q <= accept;        // capture cycle
            load  <= cap_q;         // seed after capture, one pulse
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_vld_hold: assert property (@(posedge clk) disable iff (rst)
        vld_out && !rdy_in |=> vld_out)
        else $error("vld_out dropped under back-pressure");

    a_load_step: assert property (@(posedge clk) disable iff (rst)
        load |-> !step ##1 step)
        else $error("load overlaps step or loop did not start");

endmodule

// ==== divider/div_iter_counter.sv ====
`timescale 1ns/100ps
`include "fixp_defs.svh"

module div_iter_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,      // clear for a new division
    input  logic step,      // one iteration done
    output logic last       // current step is the final one
);

    localparam int CNT_W = `DIV_CNT_W;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DIV_ITER - 1);

    logic [CNT_W-1:0] cnt;      // completed iterations

    assign last = (cnt == CNT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= '0;
        end else if (step) begin
            if (last) begin
                cnt <= '0;      // wrap, loop finished
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // counter stays inside the loop range
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        cnt <= CNT_LAST)
        else $error("iteration count past DIV_ITER-1");

endmodule

// ==== divider/divu_datapath.sv ====
`timescale 1ns/100ps
`include "fixp_defs.svh"

module divu_datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,     // seed from operand
    input  logic              step,     // resolve one quotient bit
    input  div_pkg::operand_t operand,
    input  logic              last,     // final step, register result
    output fixp_pkg::mag_t    quo_mag
);

    localparam int MAG_W = $bits(fixp_pkg::mag_t);
    localparam int QUO_W = `DIV_ITER;     // full quotient incl overflow bits

    fixp_pkg::mag_t   div_r;        // divisor copy
    fixp_pkg::mag_t   dvd_r;        // dividend bits not yet brought down
    logic [MAG_W:0]   acc;          // partial remainder, one bit wider
    logic [QUO_W-1:0] quo;          // partial quotient
    logic [MAG_W:0]   acc_shl;      // remainder with next dividend bit
    logic [MAG_W:0]   acc_diff;
    logic [MAG_W:0]   acc_next;
    logic [QUO_W-1:0] quo_next;
    logic             q_bit;
    logic             ovf;          // quotient wider than a magnitude

    // ------------------------------------------------------------
    // one restoring iteration
    // ------------------------------------------------------------
    always_comb begin
        acc_shl  = {acc[MAG_W-1:0], dvd_r[MAG_W-1]};   // zeros after the integer part
        acc_diff = acc_shl - {1'b0, div_r};
        q_bit    = (acc_shl >= {1'b0, div_r});         // zero divisor gives all ones
        acc_next = q_bit ? acc_diff : acc_shl;
        quo_next = {quo[QUO_W-2:0], q_bit};
        ovf      = |quo_next[QUO_W-1:MAG_W];
    end

    // ------------------------------------------------------------
    // loop registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            div_r <= operand.den_mag;
            dvd_r <= operand.num_mag;
            acc   <= '0;
            quo   <= '0;
        end else if (step) begin
            dvd_r <= dvd_r << 1;    // next dividend bit to the top
            acc   <= acc_next;
            quo   <= quo_next;
        end
    end

    // result, clamped to full scale on overflow
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quo_mag <= '0;
        end else if (step && last) begin
            quo_mag <= ovf ? '1 : quo_next[MAG_W-1:0];
        end
    end

endmodule

// ==== fixed_div.f ====
+incdir+common
+incdir+verification
common/fixp_pkg.sv
common/div_pkg.sv
divider/div_ctrl.sv
divider/div_iter_counter.sv
divider/divu_datapath.sv
source/sign_unit.sv
source/q_convert.sv
source/fixed_div_top.sv
verification/fixed_div_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fixed-point divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=fixed_div_sim

verilator --binary --assert -Wno-fatal \
    --top-module fixed_div_tb \
    -f fixed_div.f \
    --Mdir "$OBJ_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== source/fixed_div_top.sv ====
`timescale 1ns/100ps

module fixed_div_top (
    input  logic               clk,
    input  logic               rst,
    // upstream
    input  logic               vld_in,
    output logic               rdy_out,
    input  div_pkg::div_req_t  req,
    // downstream
    output logic               vld_out,
    input  logic               rdy_in,
    output fixp_pkg::quo_out_t quotient
);

    logic               accept;         // transfer edge, operand capture
    logic               load;           // loop seed
    logic               step;           // loop iteration
    logic               last;           // final iteration
    div_pkg::operand_t  operand;        // captured signs and magnitudes
    fixp_pkg::mag_t     quo_mag;        // unsigned quotient
    fixp_pkg::div_in_t  signed_quo;     // signed Q8.8 quotient

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    div_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (vld_in),
        .rdy_in  (rdy_in),
        .last    (last),
        .rdy_out (rdy_out),
        .vld_out (vld_out),
        .accept  (accept),
        .load    (load),
        .step    (step)
    );

    div_iter_counter u_cnt (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .step (step),
        .last (last)
    );

    // ------------------------------------------------------------
    // data path
    // ------------------------------------------------------------
    sign_unit u_sign (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .req        (req),
        .operand    (operand),
        .quo_mag    (quo_mag),
        .signed_quo (signed_quo)
    );

    divu_datapath u_divu (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step    (step),
        .operand (operand),
        .last    (last),
        .quo_mag (quo_mag)
    );

    q_convert u_conv (
        .in_q  (signed_quo),
        .out_q (quotient)
    );

endmodule

// ==== source/q_convert.sv ====
`timescale 1ns/100ps
`include "fixp_defs.svh"

module q_convert (
    input  fixp_pkg::div_in_t  in_q,    // signed Q8.8
    output fixp_pkg::quo_out_t out_q    // signed Q10.6
);

    localparam int IN_W  = $bits(fixp_pkg::div_in_t);
    localparam int OUT_W = $bits(fixp_pkg::quo_out_t);
    localparam int SHIFT = `DIV_INPUT_F - `OUTPUT_VEC_F;   // fraction bits dropped

    localparam logic signed [IN_W-1:0]  IN_FS   = {1'b0, {(IN_W-1){1'b1}}};
    localparam logic signed [IN_W-1:0]  IN_NFS  = -IN_FS;  // 16'h8001
    localparam logic signed [OUT_W-1:0] OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
    localparam logic signed [OUT_W-1:0] OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

    logic signed [IN_W-1:0]  trunc;     // low fraction bits gone
    logic signed [OUT_W-1:0] ext;       // integer part widened
    logic                    sat_hi;
    logic                    sat_lo;

    // ------------------------------------------------------------
    // format change
    // ------------------------------------------------------------
    assign trunc = in_q >>> SHIFT;      // floor, toward minus infinity
    assign ext   = OUT_W'(trunc);       // sign extension into 10 integer bits

    // ------------------------------------------------------------
    // saturation
    // ------------------------------------------------------------
    // the loop clamps an overflowing magnitude to all ones, so a
    // full scale input stands for a quotient beyond the output range
    assign sat_hi = (in_q == IN_FS);
    assign sat_lo = (in_q <= IN_NFS);   // 16'h8001 and 16'h8000

    always_comb begin
        if (sat_hi) begin
            out_q = OUT_MAX;
        end else if (sat_lo) begin
            out_q = OUT_MIN;
        end else begin
            out_q = ext;
        end
    end

endmodule

// ==== source/sign_unit.sv ====
`timescale 1ns/100ps

module sign_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,      // upstream transfer
    input  div_pkg::div_req_t  req,
    output div_pkg::operand_t  operand,     // signs and magnitudes held
    input  fixp_pkg::mag_t     quo_mag,     // unsigned loop result
    output fixp_pkg::div_in_t  signed_quo   // signed Q8.8 quotient
);

    localparam int IN_W = $bits(fixp_pkg::div_in_t);

    fixp_pkg::div_in_t mag_ext;     // magnitude with a zero sign bit

    // ------------------------------------------------------------
    // magnitude of a signed operand
    // ------------------------------------------------------------
    function automatic fixp_pkg::mag_t abs_mag(input fixp_pkg::div_in_t x);
        fixp_pkg::div_in_t neg;
        neg = ~x + 1'b1;
        if (!x[IN_W-1]) begin
            abs_mag = x[IN_W-2:0];          // already positive
        end else if (neg[IN_W-1]) begin
            abs_mag = '1;                   // 16'h8000 has no positive twin
        end else begin
            abs_mag = neg[IN_W-2:0];
        end
    endfunction

    // ------------------------------------------------------------
    // capture on the accepting edge
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            operand <= '0;
        end else if (accept) begin
            operand.q_sign  <= req.num[IN_W-1] ^ req.den[IN_W-1];
            operand.num_mag <= abs_mag(req.num);
            operand.den_mag <= abs_mag(req.den);
        end
    end

    // ------------------------------------------------------------
    // sign back onto the quotient
    // ------------------------------------------------------------
    assign mag_ext    = {1'b0, quo_mag};
    assign signed_quo = operand.q_sign ? (~mag_ext + 1'b1) : mag_ext;  // full scale -> 16'h8001

endmodule

// ==== verification/fixed_div_vectors.svh ====
`ifndef FIXED_DIV_VECTORS_SVH
`define FIXED_DIV_VECTORS_SVH

// ------------------------------------------------------------
// columns: numerator Q8.8, denominator Q8.8, expected Q10.6,
// stall cycles (HOLD_RANDOM picks 0..MAX_HOLD)
// ------------------------------------------------------------
localparam int NUM_VEC = 22;

localparam vec_t VEC_TABLE [NUM_VEC] = '{
    // sign combinations
    {16'h0600, 16'h0180, 16'h0100, 8'd0},           // 6.0 / 1.5 = 4.0
    {16'h0600, 16'hFE80, 16'hFF00, 8'd2},           // 6.0 / -1.5 = -4.0
    {16'hFA00, 16'h0180, 16'hFF00, HOLD_RANDOM},    // -6.0 / 1.5
    {16'hFA00, 16'hFE80, 16'h0100, 8'd1},           // -6.0 / -1.5
    // fractional results, low bits truncated
    {16'h0100, 16'h0300, 16'h0015, 8'd0},           // 1/3 -> 21/64
    {16'hFF00, 16'h0300, 16'hFFEA, 8'd3},           // -1/3 floors to -22/64
    {16'h0700, 16'h0200, 16'h00E0, HOLD_RANDOM},    // 7.0 / 2.0 = 3.5
    {16'h0100, 16'hF900, 16'hFFF7, 8'd0},           // 1.0 / -7.0
    {16'h0300, 16'h0700, 16'h001B, 8'd5},           // 3/7 -> 27/64
    {16'hFD00, 16'h0700, 16'hFFE4, HOLD_RANDOM},    // -3/7 floors to -28/64
    {16'h0001, 16'h0100, 16'h0000, 8'd0},           // lsb / 1.0, drops to zero
    {16'hFFFF, 16'h0100, 16'hFFFF, 8'd1},           // -lsb / 1.0, floors to -1/64
    {16'h0A80, 16'hFF40, 16'hFC80, HOLD_RANDOM},    // 10.5 / -0.75 = -14.0
    {16'h0080, 16'h0040, 16'h0080, 8'd7},           // 0.5 / 0.25 = 2.0
    {16'h0000, 16'h0300, 16'h0000, 8'd0},           // zero numerator
    // overflow and divide by zero
    {16'h6400, 16'h0010, 16'h7FFF, HOLD_RANDOM},    // 100.0 / 0.0625
    {16'h9C00, 16'h0010, 16'h8000, 8'd2},           // -100.0 / 0.0625
    {16'h7FFF, 16'h0080, 16'h7FFF, 8'd0},           // max / 0.5
    {16'h0500, 16'h0000, 16'h7FFF, HOLD_RANDOM},    // 5.0 / 0
    {16'hFB00, 16'h0000, 16'h8000, 8'd4},           // -5.0 / 0
    // most negative numerator, magnitude 15'h7FFF
    {16'h8000, 16'h7FFF, 16'hFFC0, 8'd0},           // -1.0
    {16'h8000, 16'h0200, 16'hF000, HOLD_RANDOM}     // 0xC001 floors to -64.0
};

`endif

// ==== verification/fixed_div_tb.sv ====
`timescale 1ns/100ps
`include "fixp_defs.svh"

module fixed_div_tb;

    typedef struct packed {
        logic [15:0] num;       // Q8.8
        logic [15:0] den;       // Q8.8
        logic [15:0] exp_q;     // Q10.6
        logic [7:0]  hold;      // stall cycles
    } vec_t;

    localparam int          RST_CYCLES  = 8;
    localparam int          LATENCY     = `DIV_ITER + 2;   // accept edge to vld_out
    localparam int          MAX_HOLD    = 7;
    localparam logic [7:0]  HOLD_RANDOM = 8'hFF;           // stall drawn at run time
    localparam logic [31:0] SEED        = 32'h665d5de3;

`include "fixed_div_vectors.svh"

    localparam int TIMEOUT_CYC = RST_CYCLES + NUM_VEC * (LATENCY + MAX_HOLD + 10);

    logic               clk;
    logic               rst;
    logic               vld_in;
    logic               rdy_out;
    div_pkg::div_req_t  req;
    logic               vld_out;
    logic               rdy_in;
    fixp_pkg::quo_out_t quotient;

    int check_cnt  = 0;
    int err_cnt    = 0;
    int cycle_cnt  = 0;
    int accept_cnt = 0;     // upstream transfers seen
    int result_cnt = 0;     // downstream transfers seen

    fixed_div_top DUT (
        .clk      (clk),
        .rst      (rst),
        .vld_in   (vld_in),
        .rdy_out  (rdy_out),
        .req      (req),
        .vld_out  (vld_out),
        .rdy_in   (rdy_in),
        .quotient (quotient)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // ------------------------------------------------------------
    // handshake monitor and run limit
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst && vld_in && rdy_out) accept_cnt <= accept_cnt + 1;
        if (!rst && vld_out && rdy_in) result_cnt <= result_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("run timed out after %0d cycles, DUT never finished", cycle_cnt);
            $display("checks: %0d, errors: %0d", check_cnt, err_cnt + 1);  // timeout counts
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check_value(input string sig_name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        check_cnt++;
        if (act_val !== exp_val) begin
            err_cnt++;
            $display("Fail at time %0t: %s expected %0h, got %0h",
                     $time, sig_name, exp_val, act_val);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                         // drive and sample point
    endtask

    task automatic run_entry(input int idx);
        vec_t               v;
        int                 wait_cyc;
        int                 stall;
        logic               busy_valid;     // keep vld_in up while busy
        v          = VEC_TABLE[idx];
        busy_valid = idx[0];
        check_value("rdy_out", 1, {31'b0, rdy_out});    // idle before request
        req.num = v.num;
        req.den = v.den;
        vld_in  = 1'b1;
        next_cycle();                                   // accepting edge
        check_value("rdy_out", 0, {31'b0, rdy_out});
        if (busy_valid) begin
            req.num = v.den;        // swapped operands must be ignored
            req.den = v.num;
        end else begin
            vld_in = 1'b0;
        end
        wait_cyc = 0;
        while (vld_out !== 1'b1) begin
            check_value("rdy_out", 0, {31'b0, rdy_out});
            next_cycle();
            wait_cyc++;
        end
        vld_in = 1'b0;
        check_value("vld_out latency", LATENCY, wait_cyc);
        check_value("quotient", {16'h0000, v.exp_q}, {16'h0000, quotient});
        if (v.hold == HOLD_RANDOM) stall = $urandom_range(MAX_HOLD, 0);
        else stall = int'(v.hold);
        repeat (stall) begin                            // downstream stall
            next_cycle();
            check_value("vld_out", 1, {31'b0, vld_out});
            check_value("quotient", {16'h0000, v.exp_q}, {16'h0000, quotient});
            check_value("rdy_out", 0, {31'b0, rdy_out});
        end
        rdy_in = 1'b1;
        next_cycle();                                   // result taken
        rdy_in = 1'b0;
        check_value("vld_out", 0, {31'b0, vld_out});
        check_value("rdy_out", 1, {31'b0, rdy_out});
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst    = 1'b1;
        vld_in = 1'b0;
        rdy_in = 1'b0;
        req    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();
        check_value("rdy_out", 1, {31'b0, rdy_out});    // reset state
        check_value("vld_out", 0, {31'b0, vld_out});
        for (int i = 0; i < NUM_VEC; i++) begin
            run_entry(i);
        end
        next_cycle();
        next_cycle();
        check_value("accept count", NUM_VEC, accept_cnt);
        check_value("result count", NUM_VEC, result_cnt);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
